// File: mmio_config.svh
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// ----------------------------------------------------------------------
// memory map.
// ----------------------------------------------------------------------

// uart transmitter: data at +0, status at +4.
`define MMIO_UART_TX_BASE 32'h1000_0000
`define MMIO_UART_TX_END  32'h1000_0007

// clint: mtime lo/hi at +0/+4, mtimecmp lo/hi at +8/+12.
`define MMIO_CLINT_BASE   32'h0200_0000
`define MMIO_CLINT_END    32'h0200_000f

// ----------------------------------------------------------------------
// device sizing.
// ----------------------------------------------------------------------

`define MMIO_UART_BIT_CYCLES 4   // clocks per serial bit.

`define MMIO_RAM_WORDS 64        // addresses wrap modulo this depth.

`endif

// File: mmio_types_pkg.sv
`default_nettype none

package mmio_types_pkg;

    // byte address on the data side.
    typedef logic [31:0] addr_t;

    // one bus word.
    typedef logic [31:0] word_t;

    // mtime and mtimecmp width.
    typedef logic [63:0] dword_t;

endpackage

`default_nettype wire

// File: mmio_bus_pkg.sv
`default_nettype none

package mmio_bus_pkg;
    import mmio_types_pkg::*;

    // cpu side request, 66 bits.
    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  wen;
        word_t wdata;
    } dreq_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;    // original request address.
        word_t rdata;
    } dresp_t;

    // device side, addr is relative to the region base.
    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  wen;
        word_t wdata;
    } dev_req_t;

    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } dev_resp_t;

    typedef enum logic [1:0] {
        idle,
        wait_ready,
        read_valid
    } router_state_e;

endpackage

`default_nettype wire

// File: mmio_router.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmio_config.svh"

module mmio_router
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire dreq_t     dreq,
    output logic           dreq_ready,
    output dresp_t         dresp,

    output dev_req_t       uart_req,
    output dev_req_t       clint_req,
    output dev_req_t       mem_req,
    input  wire            uart_ready,
    input  wire            clint_ready,
    input  wire            mem_ready,
    input  wire dev_resp_t uart_resp,
    input  wire dev_resp_t clint_resp,
    input  wire dev_resp_t mem_resp
);

    router_state_e state_q;
    dreq_t         req_q;       // latched request.
    dreq_t         cur;         // request presented to the devices.
    logic          take_live;
    logic          fwd_valid;
    logic          dev_ready;
    logic          is_uart, is_clint, is_mem;
    logic          hold_uart, hold_clint;
    logic          dev_rvalid;
    logic          rsp_valid;
    word_t         rsp_rdata;

    function automatic logic in_range(addr_t a, addr_t lo, addr_t hi);
        return (a >= lo) && (a <= hi);
    endfunction

    function automatic dev_req_t to_dev(dreq_t r, logic v, addr_t base);
        dev_req_t d;
        d.valid = v;
        d.addr  = r.addr - base;
        d.wen   = r.wen;
        d.wdata = r.wdata;
        return d;
    endfunction

    // ------------------------------------------------------------------
    // request side.
    // ------------------------------------------------------------------

    // the live channel is open when idle, or on the cycle a read completes.
    assign take_live  = (state_q == idle) || ((state_q == read_valid) && rsp_valid);
    assign dreq_ready = take_live;

    assign cur       = take_live ? dreq : req_q;
    assign fwd_valid = take_live ? dreq.valid : ((state_q == wait_ready) && req_q.valid);

    assign is_uart  = in_range(cur.addr, `MMIO_UART_TX_BASE, `MMIO_UART_TX_END);
    assign is_clint = in_range(cur.addr, `MMIO_CLINT_BASE, `MMIO_CLINT_END);
    assign is_mem   = !is_uart && !is_clint;

    assign uart_req  = to_dev(cur, fwd_valid && is_uart, `MMIO_UART_TX_BASE);
    assign clint_req = to_dev(cur, fwd_valid && is_clint, `MMIO_CLINT_BASE);
    assign mem_req   = to_dev(cur, fwd_valid && is_mem, '0);

    assign dev_ready = is_uart ? uart_ready : (is_clint ? clint_ready : mem_ready);

    // ------------------------------------------------------------------
    // response side, decoded from the latched address.
    // ------------------------------------------------------------------

    assign hold_uart  = in_range(req_q.addr, `MMIO_UART_TX_BASE, `MMIO_UART_TX_END);
    assign hold_clint = in_range(req_q.addr, `MMIO_CLINT_BASE, `MMIO_CLINT_END);

    always_comb begin
        if (hold_uart) begin
            dev_rvalid = uart_resp.rvalid;
            rsp_rdata  = uart_resp.rdata;
        end else if (hold_clint) begin
            dev_rvalid = clint_resp.rvalid;
            rsp_rdata  = clint_resp.rdata;
        end else begin
            dev_rvalid = mem_resp.rvalid;
            rsp_rdata  = mem_resp.rdata;
        end
    end

    assign rsp_valid = (state_q == read_valid) && dev_rvalid;
    assign dresp     = '{valid: rsp_valid, addr: req_q.addr, rdata: rsp_rdata};

    // ------------------------------------------------------------------
    // state machine.
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            case (state_q)
                wait_ready: begin
                    if (dev_ready) state_q <= req_q.wen ? idle : read_valid;
                end
                idle, read_valid: begin
                    if (take_live && dreq.valid) begin
                        if (!dev_ready) state_q <= wait_ready;
                        else            state_q <= dreq.wen ? idle : read_valid;
                    end else if (rsp_valid) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_live && dreq.valid) req_q <= dreq;
    end

endmodule

`default_nettype wire

// File: mmio_uart_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmio_config.svh"

module mmio_uart_tx
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire dev_req_t req,
    output logic          ready,
    output dev_resp_t     resp,
    output logic          uart_tx
);

    localparam int unsigned bit_cycles = `MMIO_UART_BIT_CYCLES;
    localparam int unsigned cyc_w      = $clog2(bit_cycles + 1);

    logic [9:0]       shift_q;      // stop, data lsb first, start.
    logic [cyc_w-1:0] cyc_q;
    logic [3:0]       bit_q;
    logic             busy_q;
    logic             is_data;
    logic             take;
    logic             rvalid_q;
    word_t            rdata_q;

    assign is_data = !req.addr[2];  // offset 0.

    // only a data write has to wait for the frame to finish.
    assign ready = !(busy_q && req.wen && is_data);
    assign take  = req.valid && ready;

    // ------------------------------------------------------------------
    // serial frame.
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '1;
            cyc_q   <= '0;
            bit_q   <= '0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (take && req.wen && is_data) begin
                shift_q <= {1'b1, req.wdata[7:0], 1'b0};
                cyc_q   <= '0;
                bit_q   <= '0;
                busy_q  <= 1'b1;
            end
        end else if (cyc_q == cyc_w'(bit_cycles - 1)) begin
            cyc_q   <= '0;
            shift_q <= {1'b1, shift_q[9:1]};    // line idles high behind the frame.
            if (bit_q == 4'd9) busy_q <= 1'b0;
            else               bit_q  <= bit_q + 4'd1;
        end else begin
            cyc_q <= cyc_q + 1'b1;
        end
    end

    assign uart_tx = shift_q[0];

    // ------------------------------------------------------------------
    // status read.
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) rvalid_q <= 1'b0;
        else        rvalid_q <= take && !req.wen;
    end

    always_ff @(posedge clk) begin
        rdata_q <= is_data ? '0 : {31'b0, busy_q};
    end

    assign resp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: mmio_clint.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_clint
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire dev_req_t req,
    input  wire dword_t   mtime,
    output logic          ready,
    output dev_resp_t     resp,
    output dword_t        mtimecmp,
    output logic          timer_irq
);

    dword_t     cmp_q;
    logic       irq_q;
    logic       rvalid_q;
    word_t      rdata_q;
    logic [1:0] sel;

    assign sel   = req.addr[3:2];   // word offset in the block.
    assign ready = 1'b1;

    // all ones keeps the interrupt quiet out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmp_q <= '1;
        end else if (req.valid && req.wen) begin
            case (sel)
                2'd2:    cmp_q[31:0]  <= req.wdata;
                2'd3:    cmp_q[63:32] <= req.wdata;
                default: ;                          // mtime is read only.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) irq_q <= 1'b0;
        else        irq_q <= (mtime >= cmp_q);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) rvalid_q <= 1'b0;
        else        rvalid_q <= req.valid && !req.wen;
    end

    always_ff @(posedge clk) begin
        case (sel)
            2'd0:    rdata_q <= mtime[31:0];
            2'd1:    rdata_q <= mtime[63:32];
            2'd2:    rdata_q <= cmp_q[31:0];
            default: rdata_q <= cmp_q[63:32];
        endcase
    end

    assign resp      = '{rvalid: rvalid_q, rdata: rdata_q};
    assign mtimecmp  = cmp_q;
    assign timer_irq = irq_q;

endmodule

`default_nettype wire

// File: mmio_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmio_config.svh"

module mmio_ram
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire dev_req_t req,
    output logic          ready,
    output dev_resp_t     resp
);

    localparam int unsigned ram_words = `MMIO_RAM_WORDS;
    localparam int unsigned idx_w     = $clog2(ram_words);

    word_t            mem [ram_words];
    logic [idx_w-1:0] idx;
    logic             rvalid_q;
    word_t            rdata_q;

    assign idx   = req.addr[idx_w+1:2];   // upper bits alias.
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (req.valid && req.wen) mem[idx] <= req.wdata;
        rdata_q <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) rvalid_q <= 1'b0;
        else        rvalid_q <= req.valid && !req.wen;
    end

    assign resp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: mmio_top.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_top
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire dreq_t  dreq,
    input  wire dword_t mtime,
    output logic        dreq_ready,
    output dresp_t      dresp,
    output logic        uart_tx,
    output dword_t      mtimecmp,
    output logic        timer_irq
);

    dev_req_t  uart_req, clint_req, mem_req;
    logic      uart_ready, clint_ready, mem_ready;
    dev_resp_t uart_resp, clint_resp, mem_resp;

    mmio_router router_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dreq        (dreq),
        .dreq_ready  (dreq_ready),
        .dresp       (dresp),
        .uart_req    (uart_req),
        .clint_req   (clint_req),
        .mem_req     (mem_req),
        .uart_ready  (uart_ready),
        .clint_ready (clint_ready),
        .mem_ready   (mem_ready),
        .uart_resp   (uart_resp),
        .clint_resp  (clint_resp),
        .mem_resp    (mem_resp)
    );

    mmio_uart_tx uart_tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (uart_req),
        .ready   (uart_ready),
        .resp    (uart_resp),
        .uart_tx (uart_tx)
    );

    mmio_clint clint_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (clint_req),
        .mtime     (mtime),
        .ready     (clint_ready),
        .resp      (clint_resp),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

    mmio_ram ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .ready (mem_ready),
        .resp  (mem_resp)
    );

endmodule

`default_nettype wire

// File: mmio_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_assert
    import mmio_bus_pkg::*;
(
    input wire                clk,
    input wire                rst_n,
    input wire dreq_t         dreq,
    input wire                dreq_ready,
    input wire dresp_t        dresp,
    input wire dev_req_t      uart_req,
    input wire dev_req_t      clint_req,
    input wire dev_req_t      mem_req,
    input wire                uart_ready,
    input wire                clint_ready,
    input wire                mem_ready,
    input wire router_state_e state
);

    logic read_open;        // an accepted read still owes its response.
    logic dev_took;         // the addressed device takes the request this cycle.
    int   fail_count = 0;

    assign dev_took = (uart_req.valid && uart_ready) || (clint_req.valid && clint_ready)
                      || (mem_req.valid && mem_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_open <= 1'b0;
        end else if (dreq.valid && dreq_ready) begin
            read_open <= !dreq.wen;
        end else if (dresp.valid) begin
            read_open <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // router handshake.
    // ------------------------------------------------------------------

    resp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        dresp.valid |-> read_open)
        else begin
            fail_count++;
            $error("response without an accepted read");
        end

    one_device: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({uart_req.valid, clint_req.valid, mem_req.valid}))
        else begin
            fail_count++;
            $error("more than one device request valid");
        end

    // a request the device refused moves the router to wait_ready and closes the channel.
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (dreq.valid && dreq_ready && !dev_took) |=> (state == wait_ready) && !dreq_ready)
        else begin
            fail_count++;
            $error("refused request did not hold dreq_ready low in wait_ready");
        end

endmodule

bind mmio_router mmio_assert router_assert_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .dreq        (dreq),
    .dreq_ready  (dreq_ready),
    .dresp       (dresp),
    .uart_req    (uart_req),
    .clint_req   (clint_req),
    .mem_req     (mem_req),
    .uart_ready  (uart_ready),
    .clint_ready (clint_ready),
    .mem_ready   (mem_ready),
    .state       (state_q)
);

`default_nettype wire

// File: mmio_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmio_config.svh"

module mmio_tb
    import mmio_types_pkg::*;
    import mmio_bus_pkg::*;
();

    localparam int bit_cycles   = `MMIO_UART_BIT_CYCLES;
    localparam int entry_cycles = 10 * bit_cycles + 20;    // one uart frame plus margin.
    localparam int table_len    = 16;
    localparam int lfsr_words   = 8;
    localparam int step_count   = table_len + 2 * lfsr_words + 12;
    localparam int cycle_limit  = step_count * entry_cycles;

    typedef struct packed {
        logic  wen;
        addr_t addr;
        word_t wdata;
        word_t exp;
        logic  cmp;     // compare read data.
        logic  stall;   // back-pressure expected.
    } entry_t;

    // ram 0x100 and 0x204 alias words 0 and 1 of the 64-word ram.
    entry_t stim [table_len] = '{
        '{1'b1, 32'h0000_0000, 32'hdead_beef, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b1, 32'h0000_0004, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0000_0000, 32'h0000_0000, 32'hdead_beef, 1'b1, 1'b0},
        '{1'b0, 32'h0000_0004, 32'h0000_0000, 32'h1234_5678, 1'b1, 1'b0},
        '{1'b0, 32'h0000_0100, 32'h0000_0000, 32'hdead_beef, 1'b1, 1'b0},
        '{1'b1, 32'h0000_0204, 32'hcafe_f00d, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0000_0004, 32'h0000_0000, 32'hcafe_f00d, 1'b1, 1'b0},
        '{1'b1, 32'h1000_0000, 32'h0000_01a5, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h1000_0004, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0},
        '{1'b1, 32'h1000_0000, 32'h0000_003c, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0000_0000, 32'h0000_0000, 32'hdead_beef, 1'b1, 1'b1},
        '{1'b0, 32'h1000_0004, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0},
        '{1'b1, 32'h0200_0008, 32'h89ab_cdef, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b1, 32'h0200_000c, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0200_0008, 32'h0000_0000, 32'h89ab_cdef, 1'b1, 1'b0},
        '{1'b0, 32'h0200_000c, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0}
    };

    logic        clk;
    logic        rst_n;
    dreq_t       dreq;
    dword_t      mtime;
    logic        dreq_ready;
    dresp_t      dresp;
    logic        uart_tx;
    dword_t      mtimecmp;
    logic        timer_irq;

    int          error_count;
    int          check_count;
    int          cycles;
    logic [31:0] lfsr;
    logic [7:0]  tx_expect [$];
    logic [7:0]  tx_seen [$];
    word_t       rand_words [lfsr_words];

    mmio_top mmio_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dreq       (dreq),
        .mtime      (mtime),
        .dreq_ready (dreq_ready),
        .dresp      (dresp),
        .uart_tx    (uart_tx),
        .mtimecmp   (mtimecmp),
        .timer_irq  (timer_irq)
    );

    always #20 clk = ~clk;                              // 40 ns period.

    always @(posedge clk) mtime <= mtime + 64'd1;       // free-running timebase.

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // helpers.
    // ------------------------------------------------------------------

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output word_t w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[31]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // holds the request until the router takes it.
    task automatic issue(input logic wen, input addr_t req_addr, input word_t req_data,
                         output int stalls);
        stalls = 0;
        @(posedge clk);
        dreq <= '{valid: 1'b1, addr: req_addr, wen: wen, wdata: req_data};
        @(negedge clk);
        while (!dreq_ready && stalls < entry_cycles) begin
            stalls++;
            @(negedge clk);
        end
        if (!dreq_ready) begin
            error_count++;
            $display("request to address %h was never accepted", req_addr);
        end
        @(posedge clk);
        dreq <= '0;
    endtask

    task automatic read_resp(input addr_t req_addr, output word_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(negedge clk);
        while (!dresp.valid && waited < entry_cycles) begin
            waited++;
            @(negedge clk);
        end
        if (dresp.valid) begin
            rdata = dresp.rdata;
            check(64'(dresp.addr), 64'(req_addr), "response address");
        end else begin
            error_count++;
            $display("no read response for address %h", req_addr);
        end
    endtask

    task automatic access(input logic wen, input addr_t req_addr, input word_t req_data,
                          output word_t rdata, output int stalls);
        rdata = '0;
        issue(wen, req_addr, req_data, stalls);
        if (!wen) read_resp(req_addr, rdata);
    endtask

    // ------------------------------------------------------------------
    // uart line decoder, sampling at bit centres.
    // ------------------------------------------------------------------

    initial begin : uart_decoder
        logic [7:0] rx;
        int         i;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (uart_tx === 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk);
                check(64'(uart_tx), 64'd0, "uart start bit");
                for (i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    rx = {uart_tx, rx[7:1]};    // lsb first.
                end
                repeat (bit_cycles) @(negedge clk);
                check(64'(uart_tx), 64'd1, "uart stop bit");
                tx_seen.push_back(rx);
            end
        end
    end

    // ------------------------------------------------------------------
    // main sequence.
    // ------------------------------------------------------------------

    initial begin : main
        word_t  rdata;
        int     stalls;
        int     waited;
        int     n;
        dword_t t0;
        dword_t cmp;
        logic   irq_seen;

        clk         = 1'b0;
        rst_n       = 1'b0;
        dreq        = '0;
        mtime       = '0;
        error_count = 0;
        check_count = 0;
        cycles      = 0;
        lfsr        = 32'he8045639;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(64'(timer_irq), 64'd0, "timer_irq after reset");
        check(64'(uart_tx), 64'd1, "uart_tx idle after reset");
        check(64'(dresp.valid), 64'd0, "dresp valid after reset");

        for (n = 0; n < table_len; n++) begin
            access(stim[n].wen, stim[n].addr, stim[n].wdata, rdata, stalls);
            if (stim[n].wen && stim[n].addr == `MMIO_UART_TX_BASE) begin
                tx_expect.push_back(stim[n].wdata[7:0]);
            end
            if (!stim[n].wen && stim[n].cmp) begin
                check(64'(rdata), 64'(stim[n].exp), $sformatf("table entry %0d read", n));
            end
            if (stim[n].stall) begin
                check(64'(stalls > 0), 64'd1, $sformatf("table entry %0d back-pressure", n));
            end
        end
        check(mtimecmp, 64'h1_89ab_cdef, "mtimecmp port");

        // mtime read lands between request and response.
        @(negedge clk);
        t0 = mtime;
        access(1'b0, `MMIO_CLINT_BASE, '0, rdata, stalls);
        check(64'(rdata >= t0[31:0] && rdata <= mtime[31:0]), 64'd1, "mtime low read");
        access(1'b0, `MMIO_CLINT_BASE + 32'd4, '0, rdata, stalls);
        check(64'(rdata), 64'(mtime[63:32]), "mtime high read");

        // timer interrupt, high one cycle after mtime reaches mtimecmp.
        @(negedge clk);
        cmp = mtime + 64'd24;
        access(1'b1, `MMIO_CLINT_BASE + 32'd8, cmp[31:0], rdata, stalls);
        access(1'b1, `MMIO_CLINT_BASE + 32'd12, cmp[63:32], rdata, stalls);
        irq_seen = 1'b0;
        waited   = 0;
        while (waited < 40) begin
            @(negedge clk);
            check(64'(timer_irq), 64'(mtime > cmp), "timer_irq against mtime");
            if (timer_irq) irq_seen = 1'b1;
            waited++;
        end
        check(64'(irq_seen), 64'd1, "timer_irq raised");

        cmp[63:32] = 32'd1;
        access(1'b1, `MMIO_CLINT_BASE + 32'd12, cmp[63:32], rdata, stalls);
        waited = 0;
        @(negedge clk);
        while (timer_irq && waited < 4) begin
            waited++;
            @(negedge clk);
        end
        check(64'(timer_irq), 64'd0, "timer_irq after mtimecmp raised");
        check(mtimecmp, cmp, "mtimecmp port after rewrite");

        // second ram pass with lfsr data in words 32 and up.
        for (n = 0; n < lfsr_words; n++) begin
            random_word(rand_words[n]);
            access(1'b1, 32'h80 + 32'(4 * n), rand_words[n], rdata, stalls);
        end
        for (n = 0; n < lfsr_words; n++) begin
            access(1'b0, 32'h80 + 32'(4 * n), '0, rdata, stalls);
            check(64'(rdata), 64'(rand_words[n]), $sformatf("lfsr word %0d", n));
        end

        waited = 0;
        while (tx_seen.size() < tx_expect.size() && waited < 2 * entry_cycles) begin
            waited++;
            @(negedge clk);
        end
        if (tx_seen.size() != tx_expect.size()) begin
            error_count++;
            $display("uart sent %0d frames, expected %0d", tx_seen.size(), tx_expect.size());
        end
        for (n = 0; n < tx_expect.size() && n < tx_seen.size(); n++) begin
            check(64'(tx_seen[n]), 64'(tx_expect[n]), $sformatf("uart frame %0d byte", n));
        end

        error_count += mmio_top_i.router_i.router_assert_i.fail_count;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
mmio_types_pkg.sv
mmio_bus_pkg.sv
mmio_router.sv
mmio_uart_tx.sv
mmio_clint.sv
mmio_ram.sv
mmio_top.sv
mmio_assert.sv
mmio_tb.sv

// File: Makefile
SIM = obj_dir/mmio_tb_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f *.sv *.svh
	verilator --binary --timing --assert -f tb.f --top-module mmio_tb \
		--Mdir obj_dir -o mmio_tb_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
